//--- source/nullsrc_cfg.svh
`ifndef NULLSRC_CFG_SVH
`define NULLSRC_CFG_SVH

// Bus widths
`define NS_DATA_W 64
`define NS_ADDR_W 8
`define NS_APB_W 32

`define NS_NOC_ID 64'hDEAD_BEEF_0123_4567

// Word addresses of the register map
`define NS_REG_ID_LO 0
`define NS_REG_ID_HI 1
`define NS_BASE 8
`define NS_REG_CTRL (`NS_BASE + 0)
`define NS_REG_LINES (`NS_BASE + 1)
`define NS_REG_RATE (`NS_BASE + 2)
`define NS_REG_SID (`NS_BASE + 3)
`define NS_REG_SRC_PKTS (`NS_BASE + 4)
`define NS_REG_SINK_PKTS (`NS_BASE + 5)
`define NS_REG_SINK_WORDS (`NS_BASE + 6)

// Field widths of the generator settings
`define NS_LINES_W 12
`define NS_RATE_W 16

`endif

//--- source/nullsrc_pkg.sv
`include "nullsrc_cfg.svh"

package nullsrc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  //
  // Generator settings, register block to null source
  //
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                   enable;
    logic [`NS_LINES_W-1:0] lines;
    logic [`NS_RATE_W-1:0]  rate;
    logic [31:0]            sid;
  } ns_settings_t;

  ////////////////////////////////////////////////////////////////////////////
  //
  // Sink statistics, sink counter to register block
  //
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [31:0] pkts;
    logic [31:0] words;
  } ns_sink_stat_t;

endpackage

//--- source/axis_if.sv
`timescale 1ns/1ps

`include "nullsrc_cfg.svh"

interface axis_if;

  logic [`NS_DATA_W-1:0] tdata;
  logic                  tlast;
  logic                  tvalid;
  logic                  tready;

  // Stream master side
  modport src (
    output tdata, tlast, tvalid,
    input  tready
  );

  // Stream slave side, only the ready is driven
  modport snk (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface

//--- source/settings_regs.sv
`timescale 1ns/1ps

`include "nullsrc_cfg.svh"

module settings_regs
  import nullsrc_pkg::*;
(
  input  logic                  i_ce_clk,
  input  logic                  i_rst_n,
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  logic [`NS_ADDR_W-1:0] i_paddr,
  input  logic [`NS_APB_W-1:0]  i_pwdata,
  input  logic [31:0]           i_src_pkts,
  input  ns_sink_stat_t         i_sink_stat,
  output logic [`NS_APB_W-1:0]  o_prdata,
  output logic                  o_pready,
  output logic                  o_pslverr,
  output ns_settings_t          o_settings
);

  localparam logic [63:0] NOC_ID = `NS_NOC_ID;

  localparam logic [`NS_ADDR_W-1:0] A_ID_LO      = `NS_REG_ID_LO;
  localparam logic [`NS_ADDR_W-1:0] A_ID_HI      = `NS_REG_ID_HI;
  localparam logic [`NS_ADDR_W-1:0] A_CTRL       = `NS_REG_CTRL;
  localparam logic [`NS_ADDR_W-1:0] A_LINES      = `NS_REG_LINES;
  localparam logic [`NS_ADDR_W-1:0] A_RATE       = `NS_REG_RATE;
  localparam logic [`NS_ADDR_W-1:0] A_SID        = `NS_REG_SID;
  localparam logic [`NS_ADDR_W-1:0] A_SRC_PKTS   = `NS_REG_SRC_PKTS;
  localparam logic [`NS_ADDR_W-1:0] A_SINK_PKTS  = `NS_REG_SINK_PKTS;
  localparam logic [`NS_ADDR_W-1:0] A_SINK_WORDS = `NS_REG_SINK_WORDS;

  logic                  access;
  logic                  mapped;
  logic                  read_only;
  logic                  wr_en;
  logic [`NS_APB_W-1:0]  rd_data;

  logic                  ctrl_en;
  logic [`NS_LINES_W-1:0] lines_q;
  logic [`NS_RATE_W-1:0]  rate_q;
  logic [31:0]           sid_q;

  // Zero wait states, every access phase completes
  assign access = i_psel && i_penable;

  ////////////////////////////////////////////////////////////////////////////
  //
  // Address decode and read mux
  //
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    rd_data   = '0;
    case (i_paddr)
      A_ID_LO:      begin rd_data = NOC_ID[31:0];  read_only = 1'b1; end
      A_ID_HI:      begin rd_data = NOC_ID[63:32]; read_only = 1'b1; end
      A_CTRL:       rd_data = {{(`NS_APB_W-1){1'b0}}, ctrl_en};
      A_LINES:      rd_data = {{(`NS_APB_W-`NS_LINES_W){1'b0}}, lines_q};
      A_RATE:       rd_data = {{(`NS_APB_W-`NS_RATE_W){1'b0}}, rate_q};
      A_SID:        rd_data = sid_q;
      A_SRC_PKTS:   begin rd_data = i_src_pkts;        read_only = 1'b1; end
      A_SINK_PKTS:  begin rd_data = i_sink_stat.pkts;  read_only = 1'b1; end
      A_SINK_WORDS: begin rd_data = i_sink_stat.words; read_only = 1'b1; end
      default:      mapped = 1'b0;
    endcase
  end

  assign wr_en     = access && i_pwrite && mapped && !read_only;
  assign o_pready  = access;
  assign o_pslverr = access && (!mapped || (i_pwrite && read_only));
  assign o_prdata  = access ? rd_data : '0;

  // Control fields, masked to their widths on write
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_en <= 1'b0;
      lines_q <= '0;
      rate_q  <= '0;
      sid_q   <= '0;
    end else if (wr_en) begin
      case (i_paddr)
        A_CTRL:  ctrl_en <= i_pwdata[0];
        A_LINES: lines_q <= i_pwdata[`NS_LINES_W-1:0];
        A_RATE:  rate_q  <= i_pwdata[`NS_RATE_W-1:0];
        A_SID:   sid_q   <= i_pwdata;
        default: ;
      endcase
    end
  end

  assign o_settings.enable = ctrl_en;
  assign o_settings.lines  = lines_q;
  assign o_settings.rate   = rate_q;
  assign o_settings.sid    = sid_q;

endmodule

//--- source/null_source.sv
`timescale 1ns/1ps

`include "nullsrc_cfg.svh"

module null_source
  import nullsrc_pkg::*;
(
  input  logic         i_ce_clk,
  input  logic         i_rst_n,
  input  ns_settings_t i_settings,
  axis_if.src          m_axis,
  output logic [31:0]  o_src_pkts
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_HEADER,
    S_PAYLOAD,
    S_GAP
  } state_t;

  state_t                 state;
  logic                   en_q;
  logic [`NS_LINES_W-1:0] lat_lines;
  logic [`NS_RATE_W-1:0]  lat_rate;
  logic [31:0]            lat_sid;
  logic [`NS_LINES_W-1:0] line_cnt;
  logic [`NS_RATE_W-1:0]  gap_cnt;
  logic [31:0]            pkt_cnt;
  logic                   is_hdr;
  logic                   is_pay;
  logic                   beat_xfer;
  logic                   last_xfer;
  logic                   start_pkt;

  assign is_hdr    = (state == S_HEADER);
  assign is_pay    = (state == S_PAYLOAD);
  assign beat_xfer = m_axis.tvalid && m_axis.tready;
  assign last_xfer = beat_xfer && m_axis.tlast;

  // Next cycle begins a new header
  always_comb begin
    case (state)
      S_IDLE:  start_pkt = en_q;
      S_GAP:   start_pkt = en_q && (gap_cnt == '0);
      default: start_pkt = last_xfer && (lat_rate == '0) && en_q;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  //
  // Packet FSM
  //
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= S_IDLE;
      en_q     <= 1'b0;
      line_cnt <= '0;
      gap_cnt  <= '0;
    end else begin
      // Extra stage on enable delays the first header by one cycle
      en_q <= i_settings.enable;
      case (state)
        S_IDLE: begin
          if (start_pkt) state <= S_HEADER;
        end
        S_HEADER, S_PAYLOAD: begin
          if (last_xfer) begin
            if (lat_rate != '0) begin
              state   <= S_GAP;
              gap_cnt <= lat_rate - 1'b1;
            end else begin
              state <= start_pkt ? S_HEADER : S_IDLE;
            end
          end else if (beat_xfer) begin
            state    <= S_PAYLOAD;
            line_cnt <= is_hdr ? {{(`NS_LINES_W-1){1'b0}}, 1'b1} : line_cnt + 1'b1;
          end
        end
        default: begin
          if (gap_cnt == '0) state <= start_pkt ? S_HEADER : S_IDLE;
          else gap_cnt <= gap_cnt - 1'b1;
        end
      endcase
    end
  end

  // Settings sampled once per packet
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lat_lines <= '0;
      lat_rate  <= '0;
      lat_sid   <= '0;
    end else if (start_pkt) begin
      lat_lines <= i_settings.lines;
      lat_rate  <= i_settings.rate;
      lat_sid   <= i_settings.sid;
    end
  end

  // Sequence number doubles as the sent packet count
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) pkt_cnt <= '0;
    else if (last_xfer) pkt_cnt <= pkt_cnt + 1'b1;
  end

  assign m_axis.tvalid = is_hdr || is_pay;
  assign m_axis.tlast  = is_hdr ? (lat_lines == '0) : (is_pay && (line_cnt == lat_lines));
  assign m_axis.tdata  = {pkt_cnt, is_hdr ? lat_sid : {{(32-`NS_LINES_W){1'b0}}, line_cnt}};
  assign o_src_pkts    = pkt_cnt;

endmodule

//--- source/stream_sink_counter.sv
`timescale 1ns/1ps

module stream_sink_counter
  import nullsrc_pkg::*;
(
  input  logic          i_ce_clk,
  input  logic          i_rst_n,
  axis_if.snk           s_axis,
  output ns_sink_stat_t o_stat
);

  logic        ready_q;
  logic        beat;
  logic [31:0] pkt_cnt;
  logic [31:0] word_cnt;

  // Data is dropped, only the handshake matters
  assign beat = s_axis.tvalid && ready_q;

  // Ready rises after reset and stays up
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) ready_q <= 1'b0;
    else ready_q <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  //
  // Word and packet counters, wrapping at 32 bits
  //
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pkt_cnt  <= '0;
      word_cnt <= '0;
    end else if (beat) begin
      word_cnt <= word_cnt + 1'b1;
      if (s_axis.tlast) pkt_cnt <= pkt_cnt + 1'b1;
    end
  end

  assign s_axis.tready = ready_q;
  assign o_stat.pkts   = pkt_cnt;
  assign o_stat.words  = word_cnt;

endmodule

//--- source/noc_block_null_source.sv
`timescale 1ns/1ps

`include "nullsrc_cfg.svh"

module noc_block_null_source
  import nullsrc_pkg::*;
(
  input  logic                  i_ce_clk,
  input  logic                  i_rst_n,
  // APB slave
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  logic [`NS_ADDR_W-1:0] i_paddr,
  input  logic [`NS_APB_W-1:0]  i_pwdata,
  output logic [`NS_APB_W-1:0]  o_prdata,
  output logic                  o_pready,
  output logic                  o_pslverr,
  // Input stream, always drained
  input  logic [`NS_DATA_W-1:0] i_tdata,
  input  logic                  i_tlast,
  input  logic                  i_tvalid,
  output logic                  o_tready,
  // Output stream from the generator
  output logic [`NS_DATA_W-1:0] o_tdata,
  output logic                  o_tlast,
  output logic                  o_tvalid,
  input  logic                  i_tready
);

  ns_settings_t  settings;
  ns_sink_stat_t sink_stat;
  logic [31:0]   src_pkts;

  axis_if src_bus ();
  axis_if snk_bus ();

  ////////////////////////////////////////////////////////////////////////////
  //
  // Stream port mapping
  //
  ////////////////////////////////////////////////////////////////////////////
  assign o_tdata        = src_bus.tdata;
  assign o_tlast        = src_bus.tlast;
  assign o_tvalid       = src_bus.tvalid;
  assign src_bus.tready = i_tready;

  assign snk_bus.tdata  = i_tdata;
  assign snk_bus.tlast  = i_tlast;
  assign snk_bus.tvalid = i_tvalid;
  assign o_tready       = snk_bus.tready;

  settings_regs settings_regs_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .i_src_pkts(src_pkts), .i_sink_stat(sink_stat),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
    .o_settings(settings));

  null_source null_source_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_settings(settings), .m_axis(src_bus.src), .o_src_pkts(src_pkts));

  stream_sink_counter stream_sink_counter_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .s_axis(snk_bus.snk), .o_stat(sink_stat));

endmodule

//--- testbench/nullsrc_props.sv
`timescale 1ns/1ps

`include "nullsrc_cfg.svh"

module nullsrc_props (
  input logic                  i_ce_clk,
  input logic                  i_rst_n,
  input logic                  i_psel,
  input logic                  i_penable,
  input logic                  o_pslverr,
  input logic                  o_tready,
  input logic [`NS_DATA_W-1:0] o_tdata,
  input logic                  o_tlast,
  input logic                  o_tvalid,
  input logic                  i_tready
);

  ////////////////////////////////////////////////////////////////////////////
  // APB phases
  ////////////////////////////////////////////////////////////////////////////
  setup_then_access: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    (i_psel && !i_penable) |=> (i_psel && i_penable))
    else $error("APB setup phase not followed by an access phase");

  slverr_in_access: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    o_pslverr |-> (i_psel && i_penable))
    else $error("pslverr outside an access phase");

  ////////////////////////////////////////////////////////////////////////////
  // Stream handshakes
  ////////////////////////////////////////////////////////////////////////////
  // Output beat holds until it transfers
  tvalid_hold: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast)))
    else $error("Output beat changed before transfer");

  // Sink ready from the first cycle after reset
  sink_ready: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    $past(i_rst_n) |-> o_tready)
    else $error("Input ready dropped after reset");

endmodule

bind noc_block_null_source nullsrc_props nullsrc_props_i (.*);

//--- testbench/tb_noc_block_null_source.sv
`timescale 1ns/1ps

`include "nullsrc_cfg.svh"

module tb_noc_block_null_source;

  localparam int NROWS = 5;
  localparam int LIMIT = 20000;

  logic i_ce_clk, i_rst_n, i_psel, i_penable, i_pwrite;
  logic [`NS_ADDR_W-1:0] i_paddr;
  logic [`NS_APB_W-1:0]  i_pwdata, o_prdata;
  logic o_pready, o_pslverr;
  logic [`NS_DATA_W-1:0] i_tdata, o_tdata;
  logic i_tlast, i_tvalid, o_tready, o_tlast, o_tvalid, i_tready;

  // Stimulus table
  string       t_name[NROWS];
  int          t_lines[NROWS], t_rate[NROWS], t_npkts[NROWS];
  int          t_in_pkts[NROWS], t_in_words[NROWS];
  logic [31:0] t_sid[NROWS];
  bit          t_rnd[NROWS];

  integer seed = 32'h8d59_ff01;
  int errors = 0, chk_errors = 0, failed = 0, tests = 0;
  int exp_sink_pkts = 0, exp_sink_words = 0;
  logic rnd_mode = 1'b0;

  // Stream checker state
  string       cur_name = "reset";
  int          cur_lines = 0, cur_rate = 0, row_no = 0;
  logic [31:0] cur_sid = '0;
  bit          gap_chk = 0;
  logic [31:0] exp_seq = '0, beat_idx = '0, gap_len = '0;
  int          tlast_total = 0, gap_row = -1;
  logic        gap_open = 1'b0;
  logic [63:0] exp_word;
  int          rdy_r;

  noc_block_null_source noc_block_null_source_i (.*);

  initial begin
    i_ce_clk = 1'b0;
    forever #10 i_ce_clk = ~i_ce_clk;
  end

  always @(posedge i_ce_clk) begin
    rdy_r = $random(seed);
    i_tready <= rnd_mode ? rdy_r[0] : 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stream monitor
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge i_ce_clk) begin
    if (i_rst_n) begin
      if (o_tvalid && gap_open) begin
        if (gap_chk && gap_row == row_no)
          assert (gap_len == cur_rate) else begin
            $display("Error %s gap: expected %0d, actual %0d", cur_name, cur_rate, gap_len);
            chk_errors++;
          end
        gap_open <= 1'b0;
      end else if (!o_tvalid && gap_open) begin
        gap_len <= gap_len + 1;
      end
      if (o_tvalid && i_tready) begin
        exp_word = {exp_seq, (beat_idx == 0) ? cur_sid : beat_idx};
        assert (o_tdata == exp_word) else begin
          $display("Error %s tdata: expected %h, actual %h", cur_name, exp_word, o_tdata);
          chk_errors++;
        end
        assert (o_tlast == (beat_idx == cur_lines)) else begin
          $display("Error %s tlast: expected %0d, actual %0d", cur_name,
                   beat_idx == cur_lines, o_tlast);
          chk_errors++;
        end
        if (o_tlast) begin
          exp_seq     <= exp_seq + 1;
          beat_idx    <= '0;
          tlast_total <= tlast_total + 1;
          gap_open    <= 1'b1;
          gap_len     <= '0;
          gap_row     <= row_no;
        end else begin
          beat_idx <= beat_idx + 1;
        end
      end
    end
  end

  task automatic check32(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Error %s %s: expected %h, actual %h", cur_name, name, exp, act);
      errors++;
    end
  endtask

  // Zero wait states expected, the loop only guards the access phase
  task automatic apb_xfer(input logic wr, input logic [`NS_ADDR_W-1:0] addr,
                          input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge i_ce_clk);
    i_psel <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite <= wr;
    i_paddr <= addr;
    i_pwdata <= wdata;
    @(posedge i_ce_clk);
    i_penable <= 1'b1;
    do begin
      @(posedge i_ce_clk);
      n++;
    end while (!o_pready && n < 16);
    if (!o_pready) begin
      $display("Timeout waiting for pready at address %0d", addr);
      errors++;
    end
    rdata = o_prdata;
    err = o_pslverr;
    i_psel <= 1'b0;
    i_penable <= 1'b0;
    i_pwrite <= 1'b0;
  endtask

  task automatic reg_write(input logic [`NS_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_xfer(1'b1, addr, data, rd, err);
    check32($sformatf("pslverr write %0d", addr), {31'b0, exp_err}, {31'b0, err});
  endtask

  task automatic reg_check(input logic [`NS_ADDR_W-1:0] addr, input logic [31:0] exp,
                           input string name);
    logic [31:0] rd;
    logic err;
    apb_xfer(1'b0, addr, '0, rd, err);
    check32(name, exp, rd);
  endtask

  // Input packets, lengths split from the row's word total
  task automatic inject_input(input int pkts, input int words);
    int len, n;
    for (int p = 0; p < pkts; p++) begin
      len = (p == pkts - 1) ? words - (words / pkts) * (pkts - 1) : words / pkts;
      for (int k = 0; k < len; k++) begin
        i_tvalid <= 1'b1;
        i_tdata <= {p, k};
        i_tlast <= (k == len - 1);
        n = 0;
        do begin
          @(posedge i_ce_clk);
          n++;
        end while (!o_tready && n < 100);
        if (!o_tready) begin
          $display("Timeout waiting for input ready");
          errors++;
        end
      end
    end
    i_tvalid <= 1'b0;
    i_tlast <= 1'b0;
  endtask

  task automatic set_row(input int r, input string nm, input int ln, input int rt,
                         input logic [31:0] sd, input int np, input int ip, input int iw,
                         input bit rn);
    t_name[r] = nm;
    t_lines[r] = ln;
    t_rate[r] = rt;
    t_sid[r] = sd;
    t_npkts[r] = np;
    t_in_pkts[r] = ip;
    t_in_words[r] = iw;
    t_rnd[r] = rn;
  endtask

  task automatic end_test(input string nm, input int e0);
    int e;
    e = errors + chk_errors - e0;
    tests++;
    if (e != 0) failed++;
    $display("%s: %s (%0d errors)", nm, (e == 0) ? "ok" : "FAILED", e);
  endtask

  initial begin
    int e0, t0, n;
    bit saw;
    i_rst_n = 1'b0;
    i_psel = 1'b0;
    i_penable = 1'b0;
    i_pwrite = 1'b0;
    i_paddr = '0;
    i_pwdata = '0;
    i_tdata = '0;
    i_tlast = 1'b0;
    i_tvalid = 1'b0;
    i_tready = 1'b1;
    set_row(0, "hdr_only", 0, 0, 32'h1111_0001, 6, 3, 3, 0);
    set_row(1, "short_gap", 3, 2, 32'h2222_0002, 5, 2, 7, 0);
    set_row(2, "long_pkt", 40, 5, 32'h3333_0003, 3, 4, 20, 0);
    set_row(3, "rand_ready", 7, 1, 32'h4444_0004, 6, 5, 13, 1);
    set_row(4, "rand_hdr", 0, 3, 32'h5555_0005, 8, 1, 9, 1);
    repeat (10) @(posedge i_ce_clk);
    i_rst_n <= 1'b1;

    // Reset values
    e0 = errors + chk_errors;
    reg_check(`NS_REG_ID_LO, 32'h0123_4567, "id_lo");
    reg_check(`NS_REG_ID_HI, 32'hDEAD_BEEF, "id_hi");
    for (int a = `NS_REG_CTRL; a <= `NS_REG_SINK_WORDS; a++)
      reg_check(a[`NS_ADDR_W-1:0], '0, $sformatf("reset reg %0d", a));
    saw = 0;
    repeat (50) begin
      @(posedge i_ce_clk);
      if (o_tvalid) saw = 1;
    end
    assert (!saw) else begin
      $display("Output tvalid rose while the block was disabled");
      errors++;
    end
    end_test("reset", e0);

    for (int r = 0; r < NROWS; r++) begin
      e0 = errors + chk_errors;
      cur_name = t_name[r];
      cur_lines = t_lines[r];
      cur_rate = t_rate[r];
      cur_sid = t_sid[r];
      gap_chk = !t_rnd[r];
      row_no = r + 1;
      rnd_mode <= t_rnd[r];
      reg_write(`NS_REG_LINES, t_lines[r], 1'b0);
      reg_write(`NS_REG_RATE, t_rate[r], 1'b0);
      reg_write(`NS_REG_SID, t_sid[r], 1'b0);
      t0 = tlast_total;
      reg_write(`NS_REG_CTRL, 32'h1, 1'b0);
      reg_check(`NS_REG_CTRL, 32'h1, "ctrl enabled");
      fork
        inject_input(t_in_pkts[r], t_in_words[r]);
        begin
          n = 0;
          while (tlast_total - t0 < t_npkts[r] && n < LIMIT) begin
            @(posedge i_ce_clk);
            n++;
          end
          if (tlast_total - t0 < t_npkts[r]) begin
            $display("Timeout waiting for output packets in %s", t_name[r]);
            errors++;
          end
        end
      join
      exp_sink_pkts += t_in_pkts[r];
      exp_sink_words += t_in_words[r];
      // Stop in the middle of a packet where it has payload
      n = 0;
      while (t_lines[r] > 0 && beat_idx == 0 && n < LIMIT) begin
        @(posedge i_ce_clk);
        n++;
      end
      if (t_lines[r] > 0 && beat_idx == 0) begin
        $display("Timeout waiting for a payload beat in %s", t_name[r]);
        errors++;
      end
      reg_write(`NS_REG_CTRL, 32'h0, 1'b0);
      repeat (3) @(posedge i_ce_clk);
      n = 0;
      while ((o_tvalid || beat_idx != 0) && n < LIMIT) begin
        @(posedge i_ce_clk);
        n++;
      end
      if (o_tvalid || beat_idx != 0) begin
        $display("Timeout waiting for the last packet to finish in %s", t_name[r]);
        errors++;
      end
      saw = 0;
      repeat (t_rate[r] + 20) begin
        @(posedge i_ce_clk);
        if (o_tvalid) saw = 1;
      end
      assert (!saw) else begin
        $display("A new header appeared after enable was cleared in %s", t_name[r]);
        errors++;
      end
      rnd_mode <= 1'b0;
      reg_check(`NS_REG_SRC_PKTS, tlast_total, "src_pkts");
      reg_check(`NS_REG_SINK_PKTS, exp_sink_pkts, "sink_pkts");
      reg_check(`NS_REG_SINK_WORDS, exp_sink_words, "sink_words");
      end_test(t_name[r], e0);
    end

    // Register access rules
    e0 = errors + chk_errors;
    cur_name = "reg_access";
    reg_write(`NS_REG_ID_LO, 32'hFFFF_FFFF, 1'b1);
    reg_write(`NS_REG_SINK_PKTS, 32'h1234, 1'b1);
    reg_write(8'h30, 32'h55AA, 1'b1);
    reg_check(`NS_REG_ID_LO, 32'h0123_4567, "id_lo after write");
    reg_check(`NS_REG_SINK_PKTS, exp_sink_pkts, "sink_pkts after write");
    reg_write(`NS_REG_LINES, 32'hFFFF_F123, 1'b0);
    reg_check(`NS_REG_LINES, 32'h0000_0123, "lines mask");
    reg_write(`NS_REG_RATE, 32'hABCD_1234, 1'b0);
    reg_check(`NS_REG_RATE, 32'h0000_1234, "rate mask");
    reg_write(`NS_REG_SID, 32'hCAFE_F00D, 1'b0);
    reg_check(`NS_REG_SID, 32'hCAFE_F00D, "sid");
    reg_write(`NS_REG_CTRL, 32'hFFFF_FFFE, 1'b0);
    reg_check(`NS_REG_CTRL, 32'h0, "ctrl mask");
    end_test("reg_access", e0);

    $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed, errors + chk_errors);
    if (failed == 0 && errors + chk_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
source/nullsrc_pkg.sv
source/axis_if.sv
source/settings_regs.sv
source/null_source.sv
source/stream_sink_counter.sv
source/noc_block_null_source.sv
testbench/nullsrc_props.sv
testbench/tb_noc_block_null_source.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the null source testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_noc_block_null_source

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

OUT=$(./obj_dir/V"$TOP")
STATUS=$?
echo "$OUT"
if [ $STATUS -ne 0 ]; then
  echo "Simulation exited with status $STATUS"
  exit 1
fi

if echo "$OUT" | grep -q -x "=== PASS ==="; then
  exit 0
fi
echo "Pass message not found"
exit 1
